//--- btb_params.svh
// --------------------
// branch target buffer size parameters
// sets, ways, lanes per fetch block and field widths
// --------------------

`ifndef BTB_PARAMS_SVH
`define BTB_PARAMS_SVH

// set indexing
`define BTB_SETS 64
`define BTB_IDX_W 6

// associativity
`define BTB_WAYS 2

// instructions per fetch block
`define BTB_LANES 8
`define BTB_LANE_W 3

// entry fields
`define BTB_TAG_W 8
`define BTB_ASID_W 8
`define BTB_INFO_W 16

`endif

//--- btb_pkg.sv
// --------------------
// branch target buffer types
// pc fields, tag and branch info vectors
// --------------------

`include "btb_params.svh"

package btb_pkg;

	// instruction address in instruction units
	// lane in 2:0, set index in 8:3, upper part in 37:9
	typedef logic [37:0] pc38_t;

	typedef logic [`BTB_IDX_W-1:0] fetch_idx_t;
	typedef logic [`BTB_LANE_W-1:0] fetch_lane_t;
	typedef logic [$clog2(`BTB_WAYS)-1:0] btb_way_t;
	typedef logic [`BTB_ASID_W-1:0] asid_t;
	typedef logic [`BTB_TAG_W-1:0] btb_tag_t;

	// branch kind and low target bits opaque to the buffer
	typedef logic [`BTB_INFO_W-1:0] btb_info_t;

	// fold the 29 upper pc bits in byte chunks, then mix in the asid
	function automatic btb_tag_t btb_make_tag(pc38_t pc, asid_t asid);
		btb_tag_t folded;
		folded = pc[16:9] ^ pc[24:17] ^ pc[32:25] ^ {3'b000, pc[37:33]};
		return folded ^ asid;
	endfunction

endpackage

//--- btb_if.sv
// --------------------
// btb array interfaces
// set read port and single way write port
// --------------------

`timescale 1ns/1ps

`include "btb_params.svh"

interface btb_rd_if
	import btb_pkg::*;
();

	// index comes from the read request stage
	fetch_idx_t rd_idx;

	// registered set contents, one entry per way
	logic rd_valid [`BTB_WAYS];
	btb_tag_t rd_tag [`BTB_WAYS];
	fetch_lane_t rd_lane [`BTB_WAYS];
	btb_info_t rd_info [`BTB_WAYS];

	modport array (input rd_idx, output rd_valid, output rd_tag, output rd_lane, output rd_info);
	modport lookup (input rd_valid, input rd_tag, input rd_lane, input rd_info);

endinterface

interface btb_wr_if
	import btb_pkg::*;
();

	logic wr_en;
	fetch_idx_t wr_idx;
	btb_way_t wr_way;
	btb_tag_t wr_tag;
	fetch_lane_t wr_lane;
	btb_info_t wr_info;

	modport update (output wr_en, output wr_idx, output wr_way,
		output wr_tag, output wr_lane, output wr_info);
	modport array (input wr_en, input wr_idx, input wr_way,
		input wr_tag, input wr_lane, input wr_info);
	// replacement only needs to know which way got written
	modport lru (input wr_en, input wr_idx, input wr_way);

endinterface

//--- btb_array.sv
// --------------------
// btb entry storage
// flop based sets of valid, tag, lane and info per way
// synchronous read of a whole set, one way written per cycle
// --------------------

`timescale 1ns/1ps

`include "btb_params.svh"

module btb_array
	import btb_pkg::*;
(
	input logic CLK,
	input logic nRST,

	input logic rd_en,
	btb_rd_if.array rd,

	btb_wr_if.array wr
);

	// --------------------
	// storage

	logic valid_q [`BTB_SETS][`BTB_WAYS];
	btb_tag_t tag_q [`BTB_SETS][`BTB_WAYS];
	fetch_lane_t lane_q [`BTB_SETS][`BTB_WAYS];
	btb_info_t info_q [`BTB_SETS][`BTB_WAYS];

	// --------------------
	// valid bits

	always_ff @(posedge CLK or negedge nRST) begin
		if (!nRST) begin
			valid_q <= '{default: '0};
			rd.rd_valid <= '{default: '0};
		end else begin
			// read sees the old contents on a same edge write
			if (rd_en) begin
				rd.rd_valid <= valid_q[rd.rd_idx];
			end
			if (wr.wr_en) begin
				valid_q[wr.wr_idx][wr.wr_way] <= 1'b1;
			end
		end
	end

	// --------------------
	// entry payload

	always_ff @(posedge CLK) begin
		if (rd_en) begin
			rd.rd_tag <= tag_q[rd.rd_idx];
			rd.rd_lane <= lane_q[rd.rd_idx];
			rd.rd_info <= info_q[rd.rd_idx];
		end
		if (wr.wr_en) begin
			tag_q[wr.wr_idx][wr.wr_way] <= wr.wr_tag;
			lane_q[wr.wr_idx][wr.wr_way] <= wr.wr_lane;
			info_q[wr.wr_idx][wr.wr_way] <= wr.wr_info;
		end
	end

endmodule

//--- btb_lru.sv
// --------------------
// btb replacement state
// one bit per set naming the least recently used way
// --------------------

`timescale 1ns/1ps

`include "btb_params.svh"

module btb_lru
	import btb_pkg::*;
(
	input logic CLK,
	input logic nRST,

	btb_wr_if.lru wr,

	// read hit from the lookup
	input logic touch,
	input btb_way_t touch_way,
	input fetch_idx_t touch_idx,

	// victim for the update index
	input fetch_idx_t victim_idx,
	output btb_way_t victim_way
);

	logic [`BTB_SETS-1:0] lru_q;

	always_ff @(posedge CLK or negedge nRST) begin
		if (!nRST) begin
			lru_q <= '0;
		end else begin
			// the used way becomes most recent
			if (touch) begin
				lru_q[touch_idx] <= ~touch_way;
			end
			// later assignment, so a write to the same set overrides the touch
			if (wr.wr_en) begin
				lru_q[wr.wr_idx] <= ~wr.wr_way;
			end
		end
	end

	assign victim_way = lru_q[victim_idx];

endmodule

//--- btb_lookup.sv
// --------------------
// btb lookup
// tag compare on the registered set, picks the first predicted
// lane at or after the fetch lane, flags hits in both ways
// --------------------

`timescale 1ns/1ps

`include "btb_params.svh"

module btb_lookup
	import btb_pkg::*;
(
	btb_rd_if.lookup rd,

	input logic resp_valid,
	input fetch_idx_t resp_idx,
	input pc38_t pc38,
	input asid_t asid,

	output logic hit,
	output btb_way_t hit_way,
	output fetch_lane_t hit_lane,
	output logic double_hit,
	output btb_info_t btb_info,

	// lru update on a hit
	output logic touch,
	output btb_way_t touch_way,
	output fetch_idx_t touch_idx
);

	btb_tag_t pc_tag;
	fetch_lane_t pc_lane;
	logic [`BTB_LANES-1:0] lane_ok;
	logic [`BTB_WAYS-1:0] qual;
	btb_way_t sel_way;

	assign pc_tag = btb_make_tag(pc38, asid);
	assign pc_lane = pc38[`BTB_LANE_W-1:0];

	always_comb begin
		// lanes at or after the fetch lane
		for (int i = 0; i < `BTB_LANES; i++) begin
			lane_ok[i] = (fetch_lane_t'(i) >= pc_lane);
		end
		for (int w = 0; w < `BTB_WAYS; w++) begin
			qual[w] = rd.rd_valid[w] && (rd.rd_tag[w] == pc_tag) && lane_ok[rd.rd_lane[w]];
		end

		// earlier branch wins when both ways qualify
		// equal lanes go to way 0
		if (&qual) begin
			sel_way = (rd.rd_lane[1] < rd.rd_lane[0]) ? 1'b1 : 1'b0;
		end else begin
			sel_way = qual[1] ? 1'b1 : 1'b0;
		end

		hit = 1'b0;
		hit_way = '0;
		hit_lane = '0;
		double_hit = 1'b0;
		btb_info = '0;
		if (resp_valid && |qual) begin
			hit = 1'b1;
			hit_way = sel_way;
			hit_lane = rd.rd_lane[sel_way];
			double_hit = &qual;
			btb_info = rd.rd_info[sel_way];
		end
	end

	assign touch = hit;
	assign touch_way = hit_way;
	assign touch_idx = resp_valid ? resp_idx : '0;

endmodule

//--- btb_update.sv
// --------------------
// btb update write builder
// rewrites a known way or allocates the lru victim
// --------------------

`timescale 1ns/1ps

`include "btb_params.svh"

module btb_update
	import btb_pkg::*;
(
	input logic update_valid,
	input pc38_t update_pc38,
	input btb_info_t update_btb_info,
	input logic update_hit,
	input btb_way_t update_hit_way,

	input asid_t asid,

	// victim lookup in the lru
	output fetch_idx_t victim_idx,
	input btb_way_t victim_way,

	btb_wr_if.update wr
);

	fetch_idx_t upd_idx;
	fetch_lane_t upd_lane;

	assign upd_idx = update_pc38[`BTB_LANE_W +: `BTB_IDX_W];
	assign upd_lane = update_pc38[`BTB_LANE_W-1:0];

	assign victim_idx = upd_idx;

	assign wr.wr_en = update_valid;
	assign wr.wr_idx = upd_idx;
	// known hit keeps its way, otherwise allocate
	assign wr.wr_way = update_hit ? update_hit_way : victim_way;
	// tag under the current address space
	assign wr.wr_tag = btb_make_tag(update_pc38, asid);
	assign wr.wr_lane = upd_lane;
	assign wr.wr_info = update_btb_info;

endmodule

//--- btb.sv
// --------------------
// branch target buffer core
// read request stage, response stage lookup and update path
// --------------------

`timescale 1ns/1ps

module btb
	import btb_pkg::*;
(
	input logic CLK,
	input logic nRST,

	input asid_t arch_asid,

	// read request stage
	input logic read_req_valid,
	input fetch_idx_t read_req_fetch_idx,

	// read response stage
	input pc38_t read_resp_pc38,
	output logic read_resp_hit,
	output btb_way_t read_resp_hit_way,
	output fetch_lane_t read_resp_hit_lane,
	output logic read_resp_double_hit,
	output btb_info_t read_resp_btb_info,

	// update
	input logic update_valid,
	input pc38_t update_pc38,
	input btb_info_t update_btb_info,
	input logic update_hit,
	input btb_way_t update_hit_way
);

	btb_rd_if rd_if ();
	btb_wr_if wr_if ();

	logic resp_valid;
	fetch_idx_t resp_idx;

	logic touch;
	btb_way_t touch_way;
	fetch_idx_t touch_idx;
	fetch_idx_t victim_idx;
	btb_way_t victim_way;

	// --------------------
	// response stage

	always_ff @(posedge CLK or negedge nRST) begin
		if (!nRST) begin
			resp_valid <= 1'b0;
			resp_idx <= '0;
		end else begin
			resp_valid <= read_req_valid;
			resp_idx <= read_req_fetch_idx;
		end
	end

	assign rd_if.rd_idx = read_req_fetch_idx;

	// --------------------
	// blocks

	btb_array u_array (
		.CLK(CLK),
		.nRST(nRST),
		.rd_en(read_req_valid),
		.rd(rd_if.array),
		.wr(wr_if.array)
	);

	btb_lru u_lru (
		.CLK(CLK),
		.nRST(nRST),
		.wr(wr_if.lru),
		.touch(touch),
		.touch_way(touch_way),
		.touch_idx(touch_idx),
		.victim_idx(victim_idx),
		.victim_way(victim_way)
	);

	btb_lookup u_lookup (
		.rd(rd_if.lookup),
		.resp_valid(resp_valid),
		.resp_idx(resp_idx),
		.pc38(read_resp_pc38),
		.asid(arch_asid),
		.hit(read_resp_hit),
		.hit_way(read_resp_hit_way),
		.hit_lane(read_resp_hit_lane),
		.double_hit(read_resp_double_hit),
		.btb_info(read_resp_btb_info),
		.touch(touch),
		.touch_way(touch_way),
		.touch_idx(touch_idx)
	);

	btb_update u_update (
		.update_valid(update_valid),
		.update_pc38(update_pc38),
		.update_btb_info(update_btb_info),
		.update_hit(update_hit),
		.update_hit_way(update_hit_way),
		.asid(arch_asid),
		.victim_idx(victim_idx),
		.victim_way(victim_way),
		.wr(wr_if.update)
	);

endmodule

//--- btb_wrapper.sv
// --------------------
// btb top level
// flops every input and every read result around the core
// --------------------

`timescale 1ns/1ps

module btb_wrapper
	import btb_pkg::*;
(
	input logic CLK,
	input logic nRST,

	input asid_t next_arch_asid,

	// read request stage
	input logic next_read_req_valid,
	input fetch_idx_t next_read_req_fetch_idx,

	// read response stage
	input pc38_t next_read_resp_pc38,
	output logic last_read_resp_hit,
	output btb_way_t last_read_resp_hit_way,
	output fetch_lane_t last_read_resp_hit_lane,
	output logic last_read_resp_double_hit,
	output btb_info_t last_read_resp_btb_info,

	// update
	input logic next_update_valid,
	input pc38_t next_update_pc38,
	input btb_info_t next_update_btb_info,
	input logic next_update_hit,
	input btb_way_t next_update_hit_way
);

	asid_t arch_asid;
	logic read_req_valid;
	fetch_idx_t read_req_fetch_idx;
	pc38_t read_resp_pc38;
	logic read_resp_hit;
	btb_way_t read_resp_hit_way;
	fetch_lane_t read_resp_hit_lane;
	logic read_resp_double_hit;
	btb_info_t read_resp_btb_info;
	logic update_valid;
	pc38_t update_pc38;
	btb_info_t update_btb_info;
	logic update_hit;
	btb_way_t update_hit_way;

	btb u_btb (.*);

	// --------------------
	// boundary flops

	always_ff @(posedge CLK or negedge nRST) begin
		if (!nRST) begin
			arch_asid <= '0;
			read_req_valid <= 1'b0;
			read_req_fetch_idx <= '0;
			read_resp_pc38 <= '0;
			last_read_resp_hit <= 1'b0;
			last_read_resp_hit_way <= '0;
			last_read_resp_hit_lane <= '0;
			last_read_resp_double_hit <= 1'b0;
			last_read_resp_btb_info <= '0;
			update_valid <= 1'b0;
			update_pc38 <= '0;
			update_btb_info <= '0;
			update_hit <= 1'b0;
			update_hit_way <= '0;
		end else begin
			arch_asid <= next_arch_asid;
			read_req_valid <= next_read_req_valid;
			read_req_fetch_idx <= next_read_req_fetch_idx;
			read_resp_pc38 <= next_read_resp_pc38;
			// lookup result of the previous cycle
			last_read_resp_hit <= read_resp_hit;
			last_read_resp_hit_way <= read_resp_hit_way;
			last_read_resp_hit_lane <= read_resp_hit_lane;
			last_read_resp_double_hit <= read_resp_double_hit;
			last_read_resp_btb_info <= read_resp_btb_info;
			update_valid <= next_update_valid;
			update_pc38 <= next_update_pc38;
			update_btb_info <= next_update_btb_info;
			update_hit <= next_update_hit;
			update_hit_way <= next_update_hit_way;
		end
	end

endmodule

//--- btb_tb.sv
// --------------------
// btb testbench
// replays operations from the patterns file through the wrapper
// and compares every read result with the expected values
// --------------------

`timescale 1ns/1ps

`include "btb_params.svh"

module btb_tb
	import btb_pkg::*;
();

	logic CLK;
	logic nRST;
	asid_t next_arch_asid;
	logic next_read_req_valid;
	fetch_idx_t next_read_req_fetch_idx;
	pc38_t next_read_resp_pc38;
	logic last_read_resp_hit;
	btb_way_t last_read_resp_hit_way;
	fetch_lane_t last_read_resp_hit_lane;
	logic last_read_resp_double_hit;
	btb_info_t last_read_resp_btb_info;
	logic next_update_valid;
	pc38_t next_update_pc38;
	btb_info_t next_update_btb_info;
	logic next_update_hit;
	btb_way_t next_update_hit_way;

	integer fd;
	integer code;
	integer errors;
	integer checks;
	integer nlines;
	integer limit_ns;
	integer ops;
	logic [7:0] op;
	logic [8*128-1:0] line;
	pc38_t pc_v;
	logic [31:0] f1, f2, f3, f4, f5;

	btb_wrapper DUT (.*);

	initial begin
		CLK = 1'b0;
		forever #2 CLK = ~CLK;
	end

	// --------------------
	// checks and operations

	task automatic check_val(input string name, input logic [31:0] exp_val,
		input logic [31:0] act_val);
		checks++;
		if (exp_val !== act_val) begin
			$display("Fail %s expected %h got %h at %0t", name, exp_val, act_val, $time);
			errors++;
		end
	endtask

	task automatic check_resp(input logic [31:0] hit, input logic [31:0] way,
		input logic [31:0] lane, input logic [31:0] dbl, input logic [31:0] info);
		check_val("last_read_resp_hit", hit, 32'(last_read_resp_hit));
		check_val("last_read_resp_hit_way", way, 32'(last_read_resp_hit_way));
		check_val("last_read_resp_hit_lane", lane, 32'(last_read_resp_hit_lane));
		check_val("last_read_resp_double_hit", dbl, 32'(last_read_resp_double_hit));
		check_val("last_read_resp_btb_info", info, 32'(last_read_resp_btb_info));
	endtask

	// no read in flight, so the result flops stay zero
	task automatic idle_cycle();
		@(negedge CLK);
		check_resp(0, 0, 0, 0, 0);
	endtask

	// request on one edge, pc on the next, result after the third edge
	task automatic do_read(input pc38_t pc, input logic [31:0] hit, input logic [31:0] way,
		input logic [31:0] lane, input logic [31:0] dbl, input logic [31:0] info);
		@(negedge CLK);
		next_read_req_valid = 1'b1;
		next_read_req_fetch_idx = pc[8:3];
		@(negedge CLK);
		next_read_req_valid = 1'b0;
		next_read_resp_pc38 = pc;
		repeat (2) @(negedge CLK);
		check_resp(hit, way, lane, dbl, info);
	endtask

	task automatic do_update(input pc38_t pc, input logic [31:0] info,
		input logic [31:0] hit, input logic [31:0] way);
		@(negedge CLK);
		next_update_valid = 1'b1;
		next_update_pc38 = pc;
		next_update_btb_info = info[15:0];
		next_update_hit = hit[0];
		next_update_hit_way = way[0];
		@(negedge CLK);
		next_update_valid = 1'b0;
		next_update_hit = 1'b0;
		repeat (2) idle_cycle();
	endtask

	// --------------------
	// main sequence

	initial begin
		errors = 0;
		checks = 0;
		nlines = 0;
		limit_ns = 0;
		ops = 0;
		nRST = 1'b0;
		next_arch_asid = '0;
		next_read_req_valid = 1'b0;
		next_read_req_fetch_idx = '0;
		next_read_resp_pc38 = '0;
		next_update_valid = 1'b0;
		next_update_pc38 = '0;
		next_update_btb_info = '0;
		next_update_hit = 1'b0;
		next_update_hit_way = '0;
		repeat (2) @(posedge CLK);
		@(negedge CLK);
		nRST = 1'b1;

		fd = $fopen("btb_patterns.txt", "r");
		if (fd == 0) begin
			$display("could not open the patterns file");
			errors++;
		end else begin
			// line count sizes the watchdog
			while ($fgets(line, fd) != 0) begin
				nlines++;
			end
			limit_ns = nlines * 8 * 4 + 200;
			$fclose(fd);
			fd = $fopen("btb_patterns.txt", "r");
			while ($fscanf(fd, " %c", op) == 1) begin
				case (op)
					"#": code = $fgets(line, fd);
					"A": begin
						code = $fscanf(fd, "%h", f1);
						if (code != 1) begin
							$display("malformed address space line in the patterns file");
							errors++;
						end else begin
							@(negedge CLK);
							next_arch_asid = f1[7:0];
						end
						ops++;
					end
					"U": begin
						code = $fscanf(fd, "%h %h %h %h", pc_v, f1, f2, f3);
						if (code != 4) begin
							$display("malformed update line in the patterns file");
							errors++;
						end else begin
							do_update(pc_v, f1, f2, f3);
						end
						ops++;
					end
					"R": begin
						code = $fscanf(fd, "%h %h %h %h %h %h", pc_v, f1, f2, f3, f4, f5);
						if (code != 6) begin
							$display("malformed read line in the patterns file");
							errors++;
						end else begin
							do_read(pc_v, f1, f2, f3, f4, f5);
						end
						ops++;
					end
					"I": begin
						code = $fscanf(fd, "%d", f1);
						if (code != 1) begin
							$display("malformed idle line in the patterns file");
							errors++;
						end else begin
							repeat (f1) idle_cycle();
						end
						ops++;
					end
					default: begin
						$display("unknown operation %c in the patterns file", op);
						errors++;
						code = $fgets(line, fd);
					end
				endcase
			end
			$fclose(fd);
			if (ops == 0) begin
				$display("the patterns file holds no operations");
				errors++;
			end
		end

		$display("%0d errors in %0d checks", errors, checks);
		if (errors == 0) begin
			$display("No errors");
		end else begin
			$display("Errors found");
		end
		$finish;
	end

	// watchdog sized at about 8 cycles per patterns line plus margin
	initial begin
		wait (limit_ns > 0);
		#(limit_ns);
		$display("watchdog expired before all operations were replayed");
		$display("Errors found");
		$finish;
	end

endmodule

//--- btb_patterns.txt
# A asid | U pc info hit way | R pc exp_hit exp_way exp_lane exp_double_hit exp_info
# I idle_cycles (decimal), every other field hex
# empty buffer after reset
I 2
R 000000000a 0 0 0 0 0000
R 0000000015 0 0 0 0 0000
A 05
# allocate set 2 lane 5, read below, at and above the branch
U 0000000015 1234 0 0
R 0000000012 1 0 5 0 1234
R 0000000015 1 0 5 0 1234
R 0000000016 0 0 0 0 0000
I 1
# second branch at lane 3 lands in the other way
U 0000000013 abcd 0 0
R 0000000011 1 1 3 1 abcd
R 0000000014 1 0 5 0 1234
R 0000000013 1 1 3 1 abcd
# other address space misses, switching back hits again
A 06
R 0000000014 0 0 0 0 0000
A 05
R 0000000014 1 0 5 0 1234
# set 5 replacement, tags differ in the upper pc bits
U 0000000029 1111 0 0
U 0000000229 2222 0 0
R 0000000029 1 0 1 0 1111
U 0200040029 3333 0 0
R 0000000229 0 0 0 0 0000
R 0000000029 1 0 1 0 1111
R 0200040029 1 1 1 0 3333
U 0000000229 4444 0 0
R 0000000029 0 0 0 0 0000
R 0000000229 1 0 1 0 4444
# rewrite way 1 in place
U 020004002c 5555 1 1
R 0000000229 1 0 1 0 4444
R 020004002a 1 1 4 0 5555
I 2

//--- tb.f
+incdir+.
btb_pkg.sv
btb_if.sv
btb_array.sv
btb_lru.sv
btb_lookup.sv
btb_update.sv
btb.sv
btb_wrapper.sv
btb_tb.sv
